//--- dv/sdram_trace.txt
// Columns: word address, expected dout {beat1, beat0}, expected bank
// Beat 0 = address[15:0], beat 1 = beat 0 with bit 0 flipped, bank = address[9:8]
000000 00010000 0
000100 01010100 1
000200 02010200 2
000300 03010300 3
012345 23442345 3
0abcde bcdfbcde 0
7fffff fffeffff 3
400155 01540155 1
123456 34573456 0
000201 02000201 2
0002fe 02ff02fe 2
3c0a7f 0a7e0a7f 2

//--- flist.f
+incdir+source
source/sdram_pkg.sv
source/sdram_req_if.sv
source/sdram_req_queue.sv
source/sdram_rfsh_regs.sv
source/sdram_bank_core.sv
source/sdram_subsys.sv
dv/sdram_model.sv
dv/tb_sdram_subsys.sv

//--- run.sh
#!/bin/sh
# Build and run the SDRAM subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_sdram_subsys -f flist.f -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if grep -q "Verification passed" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

//--- dv/tb_sdram_subsys.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_defines.svh"

module tb_sdram_subsys;

    localparam int NUM_REQ     = 12;
    localparam int CYCLE_LIMIT = `SDRAM_INIT_WAIT + 64 * NUM_REQ + 2000;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic [22:0] req_addr;
    logic        req_full;
    logic        rdy;
    logic [1:0]  ba_rdy;
    logic [31:0] dout;
    logic        cfg_wr;
    logic [1:0]  cfg_addr;
    logic [15:0] cfg_wdata;
    logic [15:0] cfg_rdata;
    wire  [15:0] dq;
    logic [12:0] a;
    logic [1:0]  ba;
    logic        ncs, nras, ncas, nwe, dqml, dqmh, cke;
    logic        init_ok;
    logic        order_err;

    logic [31:0] trace_mem [0:3*NUM_REQ-1];   // addr, dout, bank per line
    int          issued;
    int          rd_idx;
    int          cycles;
    logic        full_seen;
    logic [15:0] val;
    int          gap;

    sdram_subsys UUT (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_addr(req_addr),
        .req_full(req_full), .rdy(rdy), .ba_rdy(ba_rdy), .dout(dout),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
        .dq(dq), .a(a), .ba(ba), .ncs(ncs), .nras(nras), .ncas(ncas), .nwe(nwe),
        .dqml(dqml), .dqmh(dqmh), .cke(cke)
    );

    sdram_model u_mem (
        .clk(clk), .dq(dq), .a(a), .ba(ba), .ncs(ncs), .nras(nras), .ncas(ncas),
        .nwe(nwe), .init_ok(init_ok), .order_err(order_err)
    );

    always #4 clk = ~clk;   // 8 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_dout(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t dout got %h expected %h", $time, got, exp);
            abort_run("dout mismatch");
        end
    endtask

    task automatic check_bank(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t ba_rdy got %h expected %h", $time, got, exp);
            abort_run("ba_rdy mismatch");
        end
    endtask

    task automatic check_cfg(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run("register readback mismatch");
        end
    endtask

    task automatic check_pin(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
            abort_run("SDRAM pin level wrong");
        end
    endtask

    // One strobe, only while the queue has room
    task automatic issue_req(input int idx);
        while (req_full) @(negedge clk);
        req_valid = 1'b1;
        req_addr  = trace_mem[3*idx][22:0];
        issued    = issued + 1;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic write_cfg(input logic [1:0] addr, input logic [15:0] data);
        @(negedge clk);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_wr    = 1'b0;
    endtask

    task automatic read_cfg(input logic [1:0] addr, output logic [15:0] data);
        @(negedge clk);
        cfg_addr = addr;
        #1 data = cfg_rdata;     // Combinational path settled
    endtask

    task automatic wait_done();
        while (rd_idx < issued) @(negedge clk);
    endtask

    // Completions checked in request order
    always @(negedge clk) begin
        if (!rst && rdy) begin
            if (!init_ok) abort_run("rdy pulsed before init completed");
            else if (rd_idx >= issued) abort_run("rdy pulsed with no request outstanding");
            else begin
                check_dout(dout, trace_mem[3*rd_idx+1]);
                check_bank(ba_rdy, trace_mem[3*rd_idx+2][1:0]);
                rd_idx = rd_idx + 1;
            end
        end
        if (!rst) begin
            check_pin("cke", cke, 1'b1);
            if ({ncs, nras, ncas, nwe} == sdram_pkg::CMD_READ) begin
                check_pin("dqml", dqml, 1'b0);   // Read data never masked
                check_pin("dqmh", dqmh, 1'b0);
            end
        end
        if (req_full) full_seen = 1'b1;
        if (order_err) abort_run("SDRAM model saw a wrong command order");
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) abort_run("Timeout waiting for read completions");
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_addr  = '0;
        cfg_wr    = 1'b0;
        cfg_addr  = 2'd0;
        cfg_wdata = 16'd0;
        issued    = 0;
        rd_idx    = 0;
        cycles    = 0;
        full_seen = 1'b0;
        gap       = $urandom(14);
        $readmemh("dv/sdram_trace.txt", trace_mem);
        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 4; i++) issue_req(i);   // Four banks, no gaps
        wait_done();
        // Refresh off since reset, count stays at zero
        read_cfg(`RFSH_ADDR_COUNT, val);
        check_cfg("cfg_rdata count", val, 16'd0);
        repeat (200) @(negedge clk);
        read_cfg(`RFSH_ADDR_COUNT, val);
        check_cfg("cfg_rdata count", val, 16'd0);
        write_cfg(`RFSH_ADDR_INTERVAL, 16'd50);
        write_cfg(`RFSH_ADDR_ENABLE, 16'd1);
        read_cfg(`RFSH_ADDR_INTERVAL, val);
        check_cfg("cfg_rdata interval", val, 16'd50);
        read_cfg(`RFSH_ADDR_ENABLE, val);
        check_cfg("cfg_rdata enable", val, 16'd1);
        repeat (500) @(negedge clk);
        read_cfg(`RFSH_ADDR_COUNT, val);
        if (val == 16'd0) abort_run("Refresh count still zero with refresh enabled");
        for (int i = 4; i < NUM_REQ; i++) begin   // Reads mixed with refreshes
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
            issue_req(i);
        end
        wait_done();
        write_cfg(`RFSH_ADDR_ENABLE, 16'd0);
        repeat (4) @(negedge clk);                 // Last due refresh drains
        write_cfg(`RFSH_ADDR_COUNT, 16'h5a5a);     // Known count to watch
        read_cfg(`RFSH_ADDR_COUNT, val);
        check_cfg("cfg_rdata count", val, 16'h5a5a);
        repeat (200) @(negedge clk);
        read_cfg(`RFSH_ADDR_COUNT, val);
        check_cfg("cfg_rdata count", val, 16'h5a5a);
        if (!full_seen) abort_run("req_full never rose during the bursts");
        else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dv/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_defines.svh"

// Behavioral SDR SDRAM, reads only, CL 2 and burst 2
module sdram_model (
    input  wire                     clk,
    inout  wire  [15:0]             dq,
    input  wire  [`SDRAM_ROW_W-1:0] a,
    input  wire  [`SDRAM_BA_W-1:0]  ba,
    input  wire                     ncs,
    input  wire                     nras,
    input  wire                     ncas,
    input  wire                     nwe,
    output logic                    init_ok,     // LOAD_MODE seen in order
    output logic                    order_err
);

    sdram_pkg::sdram_cmd_e   cmd;
    logic [2:0]              step;          // Init commands seen so far
    int                      nop_run;
    logic [`SDRAM_ROW_W-1:0] open_row [0:3];
    logic [2:0]              vld_pipe;      // READ delay line
    logic [22:0]             adr_pipe [0:2];

    assign cmd = sdram_pkg::sdram_cmd_e'({ncs, nras, ncas, nwe});

    // Beat 0 is the low address half, beat 1 flips bit 0
    assign dq = vld_pipe[1] ? adr_pipe[1][15:0] :
                vld_pipe[2] ? (adr_pipe[2][15:0] ^ 16'h0001) : 16'hzzzz;

    initial begin
        init_ok   = 1'b0;
        order_err = 1'b0;
        step      = 3'd0;
        nop_run   = 0;
        vld_pipe  = 3'd0;
    end

    task automatic order_fail(input string what);
        $display("SDRAM model at %0t ns: %s", $time, what);
        order_err <= 1'b1;
    endtask

    always @(posedge clk) begin
        vld_pipe    <= {vld_pipe[1:0], cmd == sdram_pkg::CMD_READ};
        adr_pipe[0] <= {open_row[ba][10:0], a[9:8], ba, a[7:0]};   // Word address rebuilt
        adr_pipe[1] <= adr_pipe[0];
        adr_pipe[2] <= adr_pipe[1];
        nop_run     <= (cmd == sdram_pkg::CMD_NOP) ? nop_run + 1 : 0;
        if (!init_ok) begin
            case (cmd)
                sdram_pkg::CMD_NOP: ;
                sdram_pkg::CMD_PRECHARGE:
                    if (step == 3'd0 && a[10]) step <= 3'd1;
                    else order_fail("precharge all out of order during init");
                sdram_pkg::CMD_REFRESH:
                    if (step == 3'd1) step <= 3'd2;
                    else if (step == 3'd2 && nop_run >= 11) step <= 3'd3;
                    else order_fail("refresh out of order during init");
                sdram_pkg::CMD_LOAD_MODE:
                    // CL 2 and burst 2 expected
                    if (step == 3'd3 && nop_run >= 11 && a[6:4] == 3'd2 && a[2:0] == 3'd1)
                        init_ok <= 1'b1;
                    else order_fail("mode load out of order or with a bad mode word");
                default: order_fail("access command issued before init finished");
            endcase
        end else begin
            if (cmd == sdram_pkg::CMD_ACTIVE) open_row[ba] <= a;
            if (cmd == sdram_pkg::CMD_READ && !a[10])
                order_fail("read issued without auto-precharge");
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_subsys.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_defines.svh"

module sdram_subsys (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          req_valid,
    input  wire  [`SDRAM_ADDR_W-1:0]     req_addr,
    output logic                         req_full,
    output logic                         rdy,
    output logic [`SDRAM_BA_W-1:0]       ba_rdy,
    output logic [31:0]                  dout,
    input  wire                          cfg_wr,
    input  wire  [1:0]                   cfg_addr,
    input  wire  [15:0]                  cfg_wdata,
    output logic [15:0]                  cfg_rdata,
    inout  wire  [15:0]                  dq,
    output logic [`SDRAM_ROW_W-1:0]      a,
    output logic [`SDRAM_BA_W-1:0]       ba,
    output logic                         ncs,
    output logic                         nras,
    output logic                         ncas,
    output logic                         nwe,
    output logic                         dqml,
    output logic                         dqmh,
    output logic                         cke
);

    logic rfsh_en;
    logic rfsh_start;

    sdram_req_if req_bus ();   // Queue head to core

    sdram_req_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_full  (req_full),
        .req       (req_bus.src)
    );

    sdram_rfsh_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .rfsh_start (rfsh_start),
        .rfsh_en    (rfsh_en)
    );

    sdram_bank_core u_core (
        .clk        (clk),
        .rst        (rst),
        .req        (req_bus.dst),
        .rfsh_en    (rfsh_en),
        .rfsh_start (rfsh_start),
        .rdy        (rdy),
        .ba_rdy     (ba_rdy),
        .dout       (dout),
        .sdram_dq   (dq),
        .sdram_a    (a),
        .sdram_ba   (ba),
        .sdram_ncs  (ncs),
        .sdram_nras (nras),
        .sdram_ncas (ncas),
        .sdram_nwe  (nwe),
        .sdram_dqml (dqml),
        .sdram_dqmh (dqmh),
        .sdram_cke  (cke)
    );

endmodule

`default_nettype wire

//--- source/sdram_bank_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_defines.svh"

module sdram_bank_core (
    input  wire                          clk,
    input  wire                          rst,
    sdram_req_if.dst                     req,
    input  wire                          rfsh_en,
    output logic                         rfsh_start,
    output logic                         rdy,
    output logic [`SDRAM_BA_W-1:0]       ba_rdy,
    output logic [31:0]                  dout,
    inout  wire  [15:0]                  sdram_dq,
    output logic [`SDRAM_ROW_W-1:0]      sdram_a,
    output logic [`SDRAM_BA_W-1:0]       sdram_ba,
    output logic                         sdram_ncs,
    output logic                         sdram_nras,
    output logic                         sdram_ncas,
    output logic                         sdram_nwe,
    output logic                         sdram_dqml,
    output logic                         sdram_dqmh,
    output logic                         sdram_cke
);

    // Ring slots, bit 0 means bank idle
    localparam int READ_BIT = 2;
    localparam int DQLO_BIT = 5;
    localparam int DQHI_BIT = 6;
    localparam int BQL      = 4;   // Bank queue depth, READ to rdy

    sdram_pkg::init_st_e   init_st;
    logic [13:0]           wait_cnt;
    sdram_pkg::sdram_cmd_e cmd;
    logic [7:0]            bank_st [0:3];
    logic [7:0]            all_st;
    logic                  init_done;
    logic                  activate;
    logic                  read;
    logic                  get_low;
    logic                  get_high;
    logic                  refresh;
    logic                  post_act;    // Moves the column stage forward
    logic                  rfshing;
    logic [2:0]            rfsh_cnt;
    logic [`SDRAM_COL_W-1:0] col_fifo [0:1];
    logic [`SDRAM_BA_W-1:0]  ba_fifo [0:1];
    logic [BQL*2-1:0]      ba_queue;
    logic [15:0]           dq_lo;
    logic [15:0]           dq_hi;

    assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = cmd;
    assign sdram_cke = 1'b1;
    // DQM shares A[12:11] so the pins can be shorted on some boards
    assign {sdram_dqmh, sdram_dqml} = sdram_a[12:11];
    assign sdram_dq  = 16'hzzzz;     // Reads only, bus never driven
    assign dout      = {dq_hi, dq_lo};
    assign init_done = init_st == sdram_pkg::INIT_DONE;

    always_comb begin
        all_st   = bank_st[0] | bank_st[1] | bank_st[2] | bank_st[3];
        // Target bank idle, READ slot free, no refresh running
        activate = init_done && req.rd && bank_st[req.ba][0] && !all_st[READ_BIT]
                   && !rfshing;
        read     = all_st[READ_BIT];
        get_low  = all_st[DQLO_BIT];
        get_high = all_st[DQHI_BIT];
        // Only with every bank idle and nothing waiting
        refresh  = init_done && all_st[7:1] == 7'd0 && rfsh_en && !req.rd && !rfshing;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_st    <= sdram_pkg::INIT_WAIT;
            wait_cnt   <= 14'(`SDRAM_INIT_WAIT);
            cmd        <= sdram_pkg::CMD_NOP;
            sdram_a    <= '0;
            sdram_ba   <= '0;
            for (int i = 0; i < 4; i++) bank_st[i] <= 8'd1;
            rfshing    <= 1'b0;
            rfsh_cnt   <= 3'd0;
            rfsh_start <= 1'b0;
            post_act   <= 1'b0;
            req.ack    <= 1'b0;
            rdy        <= 1'b0;
            ba_rdy     <= '0;
            ba_queue   <= '0;
        end else if (!init_done) begin
            cmd <= sdram_pkg::CMD_NOP;
            if (wait_cnt != 14'd0) begin
                wait_cnt <= wait_cnt - 14'd1;
            end else begin
                case (init_st)
                    sdram_pkg::INIT_WAIT: begin
                        cmd         <= sdram_pkg::CMD_PRECHARGE;
                        sdram_a[10] <= 1'b1;    // All banks
                        wait_cnt    <= 14'd2;
                        init_st     <= sdram_pkg::INIT_PRECHARGE;
                    end
                    sdram_pkg::INIT_PRECHARGE: begin
                        cmd      <= sdram_pkg::CMD_REFRESH;
                        wait_cnt <= 14'd11;     // 11 NOPs follow
                        init_st  <= sdram_pkg::INIT_REFRESH1;
                    end
                    sdram_pkg::INIT_REFRESH1: begin
                        cmd      <= sdram_pkg::CMD_REFRESH;
                        wait_cnt <= 14'd11;
                        init_st  <= sdram_pkg::INIT_REFRESH2;
                    end
                    sdram_pkg::INIT_REFRESH2: begin
                        cmd      <= sdram_pkg::CMD_LOAD_MODE;
                        sdram_a  <= `SDRAM_MODE_WORD;
                        wait_cnt <= 14'd2;      // tMRD
                        init_st  <= sdram_pkg::INIT_LOAD_MODE;
                    end
                    default: init_st <= sdram_pkg::INIT_DONE;
                endcase
            end
        end else begin
            cmd        <= sdram_pkg::CMD_NOP;
            req.ack    <= activate;             // Pops the queue head
            post_act   <= activate;
            rfsh_start <= refresh;
            rdy        <= get_high;
            ba_rdy     <= ba_queue[1:0];
            // Bank enters at READ and drops out with rdy
            ba_queue   <= {read ? ba_fifo[0] : 2'd0, ba_queue[BQL*2-1:2]};
            for (int i = 0; i < 4; i++) begin
                // Leaves idle on ACTIVE, then steps every cycle
                if (!bank_st[i][0] || (activate && req.ba == i[1:0]))
                    bank_st[i] <= {bank_st[i][6:0], bank_st[i][7]};
            end
            if (refresh) begin
                cmd      <= sdram_pkg::CMD_REFRESH;
                rfshing  <= 1'b1;
                rfsh_cnt <= 3'd0;
            end else if (rfshing) begin
                rfsh_cnt <= rfsh_cnt + 3'd1;
                if (rfsh_cnt == 3'd7) rfshing <= 1'b0;   // 8 cycles
            end
            if (activate) begin
                cmd      <= sdram_pkg::CMD_ACTIVE;
                sdram_a  <= req.row;
                sdram_ba <= req.ba;
            end
            if (read) begin
                cmd      <= sdram_pkg::CMD_READ;
                sdram_a  <= {2'b00, 1'b1, col_fifo[0]};  // DQM low, auto-precharge
                sdram_ba <= ba_fifo[0];
            end
        end
    end

    // Column and bank wait here between ACTIVE and READ
    always_ff @(posedge clk) begin
        if (activate) begin
            col_fifo[1] <= req.col;
            ba_fifo[1]  <= req.ba;
        end
        if (post_act) begin
            col_fifo[0] <= col_fifo[1];
            ba_fifo[0]  <= ba_fifo[1];
        end
        if (get_low) dq_lo <= sdram_dq;      // First beat
        if (get_high) dq_hi <= sdram_dq;
    end

endmodule

`default_nettype wire

//--- source/sdram_rfsh_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_defines.svh"

module sdram_rfsh_regs (
    input  wire         clk,
    input  wire         rst,
    input  wire         cfg_wr,
    input  wire  [1:0]  cfg_addr,
    input  wire  [15:0] cfg_wdata,
    output logic [15:0] cfg_rdata,
    input  wire         rfsh_start,   // Core issued REFRESH
    output logic        rfsh_en       // Refresh due
);

    logic [15:0] interval;
    logic        enable;
    logic [15:0] ivl_cnt;
    logic [15:0] rfsh_count;   // Issued refreshes

    always_comb begin
        case (cfg_addr)
            `RFSH_ADDR_INTERVAL: cfg_rdata = interval;
            `RFSH_ADDR_ENABLE:   cfg_rdata = {15'd0, enable};
            `RFSH_ADDR_COUNT:    cfg_rdata = rfsh_count;
            default:             cfg_rdata = 16'd0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            interval   <= 16'd0;
            enable     <= 1'b0;
            ivl_cnt    <= 16'd0;
            rfsh_count <= 16'd0;
            rfsh_en    <= 1'b0;
        end else begin
            if (rfsh_start) rfsh_count <= rfsh_count + 16'd1;
            if (cfg_wr) begin
                case (cfg_addr)   // A write to the count overrides an increment
                    `RFSH_ADDR_INTERVAL: interval <= cfg_wdata;
                    `RFSH_ADDR_ENABLE:   enable <= cfg_wdata[0];
                    `RFSH_ADDR_COUNT:    rfsh_count <= cfg_wdata;
                    default: ;
                endcase
            end
            if (!enable) begin
                ivl_cnt <= 16'd0;     // Pending request dropped too
                rfsh_en <= 1'b0;
            end else if (ivl_cnt == interval) begin
                ivl_cnt <= 16'd0;
                rfsh_en <= 1'b1;
            end else begin
                ivl_cnt <= ivl_cnt + 16'd1;
                if (rfsh_start) rfsh_en <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/sdram_req_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_defines.svh"

module sdram_req_queue (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     req_valid,
    input  wire [`SDRAM_ADDR_W-1:0] req_addr,
    output logic                    req_full,
    sdram_req_if.src                req
);

    logic [`SDRAM_ADDR_W-1:0] mem [0:1];
    logic [`SDRAM_ADDR_W-1:0] head;
    logic                     wr_ptr;
    logic                     rd_ptr;
    logic [1:0]               count;    // 0 to 2 entries
    logic                     push;
    logic                     pop;

    assign req_full = count == 2'd2;
    assign push     = req_valid && !req_full;    // Dropped while full
    assign pop      = req.ack && count != 2'd0;
    assign head     = mem[rd_ptr];

    // Bits [9:8] pick the bank so linear reads rotate over all four
    assign req.rd  = count != 2'd0;
    assign req.ba  = head[9:8];
    assign req.col = {head[11:10], head[7:0]};
    assign req.row = {2'b00, head[22:12]};      // Top row bits unused

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            case ({push, pop})
                2'b10: count <= count + 2'd1;
                2'b01: count <= count - 2'd1;
                default: count <= count;      // Idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= req_addr;
    end

endmodule

`default_nettype wire

//--- source/sdram_req_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdram_defines.svh"

// Queue head towards the bank core
interface sdram_req_if;
    logic                    rd;    // Head entry valid
    logic [`SDRAM_BA_W-1:0]  ba;
    logic [`SDRAM_ROW_W-1:0] row;
    logic [`SDRAM_COL_W-1:0] col;
    logic                    ack;   // Pops the head

    modport src (output rd, ba, row, col, input ack);
    modport dst (input rd, ba, row, col, output ack);

endinterface

`default_nettype wire

//--- source/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

    // {ncs, nras, ncas, nwe}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111,
        CMD_INHIBIT   = 4'b1000   // Chip deselected
    } sdram_cmd_e;

    // Power-up sequence steps
    typedef enum logic [2:0] {
        INIT_WAIT,
        INIT_PRECHARGE,
        INIT_REFRESH1,
        INIT_REFRESH2,
        INIT_LOAD_MODE,
        INIT_DONE
    } init_st_e;

endpackage

`default_nettype wire

//--- source/sdram_defines.svh
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// Address geometry, 16-bit SDR part
`define SDRAM_ROW_W   13
`define SDRAM_COL_W   10
`define SDRAM_BA_W    2
`define SDRAM_ADDR_W  23     // Client word address

// Power-up NOP cycles, about 100 us at the target clock
`define SDRAM_INIT_WAIT 10000

// Mode register: single write burst, CL 2, sequential, burst 2
`define SDRAM_MODE_WORD 13'b00_1_00_010_0_001

// Configuration port map
`define RFSH_ADDR_INTERVAL 2'd0
`define RFSH_ADDR_ENABLE   2'd1
`define RFSH_ADDR_COUNT    2'd2

`endif
